// File: source/core_region_pkg.sv
// ***********************************************************
// shared widths and word types of the memory region
// RAM words are two core words wide; LANE_SEL_BIT must match
// the byte offset of the upper lane (BUS_BE_W / 2 bytes)
// ***********************************************************
`default_nettype none

package core_region_pkg;

  // core side
  localparam int WORD_W = 32;
  localparam int CORE_BE_W = WORD_W / 8;

  // RAM and loader side
  localparam int BUS_DATA_W = 64;
  localparam int BUS_BE_W = BUS_DATA_W / 8;

  // byte address bit that picks the upper 32-bit half of a RAM word
  localparam int LANE_SEL_BIT = 2;

  // top address bits decoded by the LSU demux
  localparam int REGION_TAG_W = 12;
  localparam logic [REGION_TAG_W-1:0] LOCAL_DATA_TAG = 12'h001;

  // interrupts
  localparam int IRQ_N = 32;
  localparam int IRQ_ID_W = $clog2(IRQ_N);

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [CORE_BE_W-1:0] core_be_t;
  typedef logic [BUS_DATA_W-1:0] bus_word_t;
  typedef logic [BUS_BE_W-1:0] bus_be_t;
  typedef logic [IRQ_N-1:0] irq_vec_t;
  typedef logic [IRQ_ID_W-1:0] irq_id_t;

endpackage

`default_nettype wire

// File: source/irq_id_encoder.sv
// ***********************************************************
// purely combinational; highest set line wins
// id reads 0 both for line 0 and for no request at all,
// so pending_o must qualify id_o
// ***********************************************************
`default_nettype none

module irq_id_encoder (
  input  core_region_pkg::irq_vec_t irq_i,
  output logic                      pending_o,
  output core_region_pkg::irq_id_t  id_o
);

  assign pending_o = |irq_i;

  // later lines overwrite earlier ones
  always_comb begin
    id_o = '0;
    for (int i = 0; i < core_region_pkg::IRQ_N; i++) begin
      if (irq_i[i]) begin
        id_o = core_region_pkg::irq_id_t'(i);
      end
    end
  end

endmodule

`default_nettype wire

// File: source/lsu_demux.sv
// ***********************************************************
// steers LSU requests to the local data RAM or the ext port
// at most one access may be outstanding; the response
// source is only tracked for the last accepted request
// ***********************************************************
`default_nettype none

module lsu_demux (
  input  logic                   clk,
  input  logic                   rst_n,

  // core LSU side
  input  logic                   lsu_req_i,
  input  core_region_pkg::word_t lsu_addr_i,
  output logic                   lsu_gnt_o,
  output logic                   lsu_rvalid_o,
  output core_region_pkg::word_t lsu_rdata_o,

  // local data RAM side
  output logic                   local_req_o,
  input  logic                   local_gnt_i,
  input  logic                   local_rvalid_i,
  input  core_region_pkg::word_t local_rdata_i,

  // external bus side
  output logic                   ext_req_o,
  input  logic                   ext_gnt_i,
  input  logic                   ext_rvalid_i,
  input  core_region_pkg::word_t ext_rdata_i
);

  localparam int TAG_MSB = core_region_pkg::WORD_W - 1;
  localparam int TAG_LSB = core_region_pkg::WORD_W - core_region_pkg::REGION_TAG_W;

  logic is_local;
  logic accepted;
  // high when the last accepted request went out on the ext port
  logic resp_ext_q;

  assign is_local = (lsu_addr_i[TAG_MSB:TAG_LSB] == core_region_pkg::LOCAL_DATA_TAG);

  assign local_req_o = lsu_req_i & is_local;
  assign ext_req_o   = lsu_req_i & ~is_local;

  // grant comes from whichever side got the request
  assign lsu_gnt_o = (local_req_o & local_gnt_i) | (ext_req_o & ext_gnt_i);
  assign accepted  = lsu_req_i & lsu_gnt_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_ext_q <= 1'b0;
    end else if (accepted) begin
      resp_ext_q <= ~is_local;
    end
  end

  // only one side can answer at a time
  assign lsu_rvalid_o = local_rvalid_i | ext_rvalid_i;
  assign lsu_rdata_o  = resp_ext_q ? ext_rdata_i : local_rdata_i;

endmodule

`default_nettype wire

// File: source/ram_arbiter.sv
// ***********************************************************
// loader port always wins; core waits with gnt low
// loader addresses are forced to RAM word alignment
// core accesses are 32 bits, lane picked by LANE_SEL_BIT
// core rvalid is raised for reads and writes alike
// ***********************************************************
`default_nettype none

module ram_arbiter #(
  parameter int ADDR_W = 12
) (
  input  logic                       clk,
  input  logic                       rst_n,

  // loader, single-cycle strobe, no back-pressure
  input  logic                       ld_req_i,
  input  logic                       ld_we_i,
  input  logic [ADDR_W-1:0]          ld_addr_i,
  input  core_region_pkg::bus_be_t   ld_be_i,
  input  core_region_pkg::bus_word_t ld_wdata_i,
  output core_region_pkg::bus_word_t ld_rdata_o,

  // core, req/gnt/rvalid
  input  logic                       core_req_i,
  input  logic                       core_we_i,
  input  logic [ADDR_W-1:0]          core_addr_i,
  input  core_region_pkg::core_be_t  core_be_i,
  input  core_region_pkg::word_t     core_wdata_i,
  output logic                       core_gnt_o,
  output logic                       core_rvalid_o,
  output core_region_pkg::word_t     core_rdata_o,

  // RAM
  output logic                       ram_en_o,
  output logic                       ram_we_o,
  output logic [ADDR_W-1:0]          ram_addr_o,
  output core_region_pkg::bus_be_t   ram_be_o,
  output core_region_pkg::bus_word_t ram_wdata_o,
  input  core_region_pkg::bus_word_t ram_rdata_i
);

  localparam int OFFS_W = $clog2(core_region_pkg::BUS_BE_W);
  localparam int WORD_W = core_region_pkg::WORD_W;

  logic                     core_lane;
  core_region_pkg::bus_be_t core_be_wide;
  logic                     core_acc;
  // core access accepted last cycle, and its lane
  logic                     core_acc_q;
  logic                     core_lane_q;

  assign core_lane = core_addr_i[core_region_pkg::LANE_SEL_BIT];

  // byte enables only in the addressed half
  assign core_be_wide = core_lane ? {core_be_i, {core_region_pkg::CORE_BE_W{1'b0}}}
                                  : {{core_region_pkg::CORE_BE_W{1'b0}}, core_be_i};

  assign core_gnt_o = core_req_i & ~ld_req_i;
  assign core_acc   = core_gnt_o;

  always_comb begin
    ram_en_o = ld_req_i | core_req_i;
    if (ld_req_i) begin
      ram_we_o    = ld_we_i;
      ram_addr_o  = {ld_addr_i[ADDR_W-1:OFFS_W], {OFFS_W{1'b0}}};
      ram_be_o    = ld_be_i;
      ram_wdata_o = ld_wdata_i;
    end else begin
      ram_we_o    = core_we_i;
      ram_addr_o  = core_addr_i;
      ram_be_o    = core_be_wide;
      // same data in both lanes, be picks the one written
      ram_wdata_o = {core_wdata_i, core_wdata_i};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      core_acc_q  <= 1'b0;
      core_lane_q <= 1'b0;
    end else begin
      core_acc_q <= core_acc;
      if (core_acc) begin
        core_lane_q <= core_lane;
      end
    end
  end

  assign core_rvalid_o = core_acc_q;
  assign core_rdata_o  = core_lane_q ? ram_rdata_i[2*WORD_W-1:WORD_W]
                                     : ram_rdata_i[WORD_W-1:0];

  // loader read data lands one cycle after its strobe
  assign ld_rdata_o = ram_rdata_i;

endmodule

`default_nettype wire

// File: source/sp_ram.sv
// ***********************************************************
// single-port RAM, 2**ADDR_W bytes in BUS_DATA_W words
// byte address in; low offset bits are ignored
// read data one cycle after en_i, contents not reset
// ***********************************************************
`default_nettype none

module sp_ram #(
  parameter int ADDR_W = 12
) (
  input  logic                       clk,
  input  logic                       en_i,
  input  logic                       we_i,
  input  logic [ADDR_W-1:0]          addr_i,
  input  core_region_pkg::bus_be_t   be_i,
  input  core_region_pkg::bus_word_t wdata_i,
  output core_region_pkg::bus_word_t rdata_o
);

  localparam int OFFS_W = $clog2(core_region_pkg::BUS_BE_W);
  localparam int DEPTH  = 2 ** (ADDR_W - OFFS_W);

  core_region_pkg::bus_word_t mem [DEPTH];
  logic [ADDR_W-OFFS_W-1:0]   word_idx;

  assign word_idx = addr_i[ADDR_W-1:OFFS_W];

  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        for (int b = 0; b < core_region_pkg::BUS_BE_W; b++) begin
          if (be_i[b]) begin
            mem[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end
      // read-before-write on a write cycle
      rdata_o <= mem[word_idx];
    end
  end

endmodule

`default_nettype wire

// File: source/core_mem_region.sv
// ***********************************************************
// memory region around the core: instr and data RAMs with
// loader ports, LSU demux to an external port, irq encoder
// RAM sizes must be powers of two of at least 16 bytes
// ***********************************************************
`default_nettype none

module core_mem_region #(
  parameter int DATA_RAM_BYTES  = 4096,
  parameter int INSTR_RAM_BYTES = 4096
) (
  input  logic                       clk,
  input  logic                       rst_n,

  // interrupts
  input  core_region_pkg::irq_vec_t  irq_i,
  output logic                       irq_pending_o,
  output core_region_pkg::irq_id_t   irq_id_o,

  // core fetch
  input  logic                       instr_req_i,
  input  core_region_pkg::word_t     instr_addr_i,
  output logic                       instr_gnt_o,
  output logic                       instr_rvalid_o,
  output core_region_pkg::word_t     instr_rdata_o,

  // core LSU
  input  logic                       lsu_req_i,
  input  logic                       lsu_we_i,
  input  core_region_pkg::word_t     lsu_addr_i,
  input  core_region_pkg::core_be_t  lsu_be_i,
  input  core_region_pkg::word_t     lsu_wdata_i,
  output logic                       lsu_gnt_o,
  output logic                       lsu_rvalid_o,
  output core_region_pkg::word_t     lsu_rdata_o,

  // external bus
  output logic                       ext_req_o,
  output logic                       ext_we_o,
  output core_region_pkg::word_t     ext_addr_o,
  output core_region_pkg::core_be_t  ext_be_o,
  output core_region_pkg::word_t     ext_wdata_o,
  input  logic                       ext_gnt_i,
  input  logic                       ext_rvalid_i,
  input  core_region_pkg::word_t     ext_rdata_i,

  // instruction RAM loader
  input  logic                       ild_req_i,
  input  logic                       ild_we_i,
  input  core_region_pkg::word_t     ild_addr_i,
  input  core_region_pkg::bus_be_t   ild_be_i,
  input  core_region_pkg::bus_word_t ild_wdata_i,
  output core_region_pkg::bus_word_t ild_rdata_o,

  // data RAM loader
  input  logic                       dld_req_i,
  input  logic                       dld_we_i,
  input  core_region_pkg::word_t     dld_addr_i,
  input  core_region_pkg::bus_be_t   dld_be_i,
  input  core_region_pkg::bus_word_t dld_wdata_i,
  output core_region_pkg::bus_word_t dld_rdata_o
);

  localparam int INSTR_ADDR_W = $clog2(INSTR_RAM_BYTES);
  localparam int DATA_ADDR_W  = $clog2(DATA_RAM_BYTES);

  // LSU demux to data arbiter
  logic                   data_req;
  logic                   data_gnt;
  logic                   data_rvalid;
  core_region_pkg::word_t data_rdata;

  // instruction RAM
  logic                       iram_en;
  logic                       iram_we;
  logic [INSTR_ADDR_W-1:0]    iram_addr;
  core_region_pkg::bus_be_t   iram_be;
  core_region_pkg::bus_word_t iram_wdata;
  core_region_pkg::bus_word_t iram_rdata;

  // data RAM
  logic                       dram_en;
  logic                       dram_we;
  logic [DATA_ADDR_W-1:0]     dram_addr;
  core_region_pkg::bus_be_t   dram_be;
  core_region_pkg::bus_word_t dram_wdata;
  core_region_pkg::bus_word_t dram_rdata;

  irq_id_encoder irq_enc (
    .irq_i     (irq_i),
    .pending_o (irq_pending_o),
    .id_o      (irq_id_o)
  );

  // payload goes to both sides, only req is steered
  assign ext_we_o    = lsu_we_i;
  assign ext_addr_o  = lsu_addr_i;
  assign ext_be_o    = lsu_be_i;
  assign ext_wdata_o = lsu_wdata_i;

  lsu_demux lsu_dmx (
    .clk            (clk),
    .rst_n          (rst_n),
    .lsu_req_i      (lsu_req_i),
    .lsu_addr_i     (lsu_addr_i),
    .lsu_gnt_o      (lsu_gnt_o),
    .lsu_rvalid_o   (lsu_rvalid_o),
    .lsu_rdata_o    (lsu_rdata_o),
    .local_req_o    (data_req),
    .local_gnt_i    (data_gnt),
    .local_rvalid_i (data_rvalid),
    .local_rdata_i  (data_rdata),
    .ext_req_o      (ext_req_o),
    .ext_gnt_i      (ext_gnt_i),
    .ext_rvalid_i   (ext_rvalid_i),
    .ext_rdata_i    (ext_rdata_i)
  );

  // fetch port is read-only, full word enables
  ram_arbiter #(
    .ADDR_W (INSTR_ADDR_W)
  ) instr_arb (
    .clk           (clk),
    .rst_n         (rst_n),
    .ld_req_i      (ild_req_i),
    .ld_we_i       (ild_we_i),
    .ld_addr_i     (ild_addr_i[INSTR_ADDR_W-1:0]),
    .ld_be_i       (ild_be_i),
    .ld_wdata_i    (ild_wdata_i),
    .ld_rdata_o    (ild_rdata_o),
    .core_req_i    (instr_req_i),
    .core_we_i     (1'b0),
    .core_addr_i   (instr_addr_i[INSTR_ADDR_W-1:0]),
    .core_be_i     ('1),
    .core_wdata_i  ('0),
    .core_gnt_o    (instr_gnt_o),
    .core_rvalid_o (instr_rvalid_o),
    .core_rdata_o  (instr_rdata_o),
    .ram_en_o      (iram_en),
    .ram_we_o      (iram_we),
    .ram_addr_o    (iram_addr),
    .ram_be_o      (iram_be),
    .ram_wdata_o   (iram_wdata),
    .ram_rdata_i   (iram_rdata)
  );

  sp_ram #(
    .ADDR_W (INSTR_ADDR_W)
  ) instr_ram (
    .clk     (clk),
    .en_i    (iram_en),
    .we_i    (iram_we),
    .addr_i  (iram_addr),
    .be_i    (iram_be),
    .wdata_i (iram_wdata),
    .rdata_o (iram_rdata)
  );

  ram_arbiter #(
    .ADDR_W (DATA_ADDR_W)
  ) data_arb (
    .clk           (clk),
    .rst_n         (rst_n),
    .ld_req_i      (dld_req_i),
    .ld_we_i       (dld_we_i),
    .ld_addr_i     (dld_addr_i[DATA_ADDR_W-1:0]),
    .ld_be_i       (dld_be_i),
    .ld_wdata_i    (dld_wdata_i),
    .ld_rdata_o    (dld_rdata_o),
    .core_req_i    (data_req),
    .core_we_i     (lsu_we_i),
    .core_addr_i   (lsu_addr_i[DATA_ADDR_W-1:0]),
    .core_be_i     (lsu_be_i),
    .core_wdata_i  (lsu_wdata_i),
    .core_gnt_o    (data_gnt),
    .core_rvalid_o (data_rvalid),
    .core_rdata_o  (data_rdata),
    .ram_en_o      (dram_en),
    .ram_we_o      (dram_we),
    .ram_addr_o    (dram_addr),
    .ram_be_o      (dram_be),
    .ram_wdata_o   (dram_wdata),
    .ram_rdata_i   (dram_rdata)
  );

  sp_ram #(
    .ADDR_W (DATA_ADDR_W)
  ) data_ram (
    .clk     (clk),
    .en_i    (dram_en),
    .we_i    (dram_we),
    .addr_i  (dram_addr),
    .be_i    (dram_be),
    .wdata_i (dram_wdata),
    .rdata_o (dram_rdata)
  );

endmodule

`default_nettype wire

// File: verif/core_mem_region_checker.sv
// ************************************************************
// watches the DUT ports on the falling edge and predicts
// reads from shadow copies of both 4 KB RAMs
// only bytes written earlier in the run may be read back
// ************************************************************
`default_nettype none

module core_mem_region_checker (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [31:0] irq_i,
  input  logic        irq_pending_o,
  input  logic [4:0]  irq_id_o,
  input  logic        instr_req_i,
  input  logic [31:0] instr_addr_i,
  input  logic        instr_gnt_o,
  input  logic        instr_rvalid_o,
  input  logic [31:0] instr_rdata_o,
  input  logic        lsu_req_i,
  input  logic        lsu_we_i,
  input  logic [31:0] lsu_addr_i,
  input  logic [3:0]  lsu_be_i,
  input  logic [31:0] lsu_wdata_i,
  input  logic        lsu_gnt_o,
  input  logic        lsu_rvalid_o,
  input  logic [31:0] lsu_rdata_o,
  input  logic        ext_req_o,
  input  logic        ext_we_o,
  input  logic [31:0] ext_addr_o,
  input  logic [3:0]  ext_be_o,
  input  logic [31:0] ext_wdata_o,
  input  logic        ext_gnt_i,
  input  logic        ild_req_i,
  input  logic        ild_we_i,
  input  logic [31:0] ild_addr_i,
  input  logic [7:0]  ild_be_i,
  input  logic [63:0] ild_wdata_i,
  input  logic [63:0] ild_rdata_o,
  input  logic        dld_req_i,
  input  logic        dld_we_i,
  input  logic [31:0] dld_addr_i,
  input  logic [7:0]  dld_be_i,
  input  logic [63:0] dld_wdata_i,
  input  logic [63:0] dld_rdata_o,
  input  logic        test_done_i,
  input  logic [31:0] test_idx_i,
  input  logic        run_done_i,
  input  logic [31:0] tb_fail_i,
  output logic [31:0] err_count_o
);

  logic [7:0]  imem [4096];
  logic [7:0]  dmem [4096];
  logic        ild_chk;
  logic        dld_chk;
  logic        if_pend;
  logic        lsu_pend;
  logic        lsu_pend_rd;
  // local accesses answer exactly one cycle after the grant
  logic        lsu_pend_loc;
  logic [63:0] ild_exp;
  logic [63:0] dld_exp;
  logic [31:0] if_exp;
  logic [31:0] lsu_exp;
  int          checks;
  int          test_err;

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("FAILED %s: got %h, expected %h", name, got, exp);
    err_count_o = err_count_o + 1;
    test_err++;
  endtask

  task automatic report_problem(input string msg);
    $display("error: %s", msg);
    err_count_o = err_count_o + 1;
    test_err++;
  endtask

  initial begin
    err_count_o  = '0;
    ild_chk      = 1'b0;
    dld_chk      = 1'b0;
    if_pend      = 1'b0;
    lsu_pend     = 1'b0;
    lsu_pend_rd  = 1'b0;
    lsu_pend_loc = 1'b0;
    checks       = 0;
    test_err     = 0;
  end

  always @(negedge clk) begin : watch
    int          a;
    logic        found;
    logic [4:0]  exp_id;
    logic        exp_ext;
    logic        exp_gnt;
    if (rst_n) begin
      // responses to accesses of the previous cycle
      if (ild_chk) begin
        checks++;
        if (ild_rdata_o !== ild_exp) report_mismatch("ild_rdata_o", ild_rdata_o, ild_exp);
        ild_chk = 1'b0;
      end
      if (dld_chk) begin
        checks++;
        if (dld_rdata_o !== dld_exp) report_mismatch("dld_rdata_o", dld_rdata_o, dld_exp);
        dld_chk = 1'b0;
      end
      if (instr_rvalid_o) begin
        if (!if_pend) begin
          report_problem("instr_rvalid_o rose without an accepted fetch");
        end else begin
          checks++;
          if (instr_rdata_o !== if_exp) begin
            report_mismatch("instr_rdata_o", 64'(instr_rdata_o), 64'(if_exp));
          end
        end
        if_pend = 1'b0;
      end else if (if_pend) begin
        report_problem("instr_rvalid_o did not follow one cycle after the fetch grant");
        if_pend = 1'b0;
      end
      if (lsu_rvalid_o) begin
        if (!lsu_pend) begin
          report_problem("lsu_rvalid_o rose without an accepted LSU access");
        end else if (lsu_pend_rd) begin
          checks++;
          if (lsu_rdata_o !== lsu_exp) begin
            report_mismatch("lsu_rdata_o", 64'(lsu_rdata_o), 64'(lsu_exp));
          end
        end
        lsu_pend = 1'b0;
      end else if (lsu_pend && lsu_pend_loc) begin
        report_problem("lsu_rvalid_o did not follow one cycle after a local grant");
        lsu_pend = 1'b0;
      end

      // interrupt encoder, highest set line searched from the top
      found  = 1'b0;
      exp_id = '0;
      for (int i = 31; i >= 0; i--) begin
        if (irq_i[i] && !found) begin
          exp_id = 5'(i);
          found  = 1'b1;
        end
      end
      if (irq_pending_o !== found) begin
        report_mismatch("irq_pending_o", 64'(irq_pending_o), 64'(found));
      end
      if (irq_id_o !== exp_id) report_mismatch("irq_id_o", 64'(irq_id_o), 64'(exp_id));

      exp_ext = lsu_req_i && (lsu_addr_i[31:20] != 12'h001);
      if (ext_req_o !== exp_ext) report_mismatch("ext_req_o", 64'(ext_req_o), 64'(exp_ext));

      // loader strobes hold off the core grant of their own RAM
      exp_gnt = instr_req_i && !ild_req_i;
      if (instr_gnt_o !== exp_gnt) begin
        report_mismatch("instr_gnt_o", 64'(instr_gnt_o), 64'(exp_gnt));
      end
      exp_gnt = lsu_req_i && (exp_ext ? ext_gnt_i : !dld_req_i);
      if (lsu_gnt_o !== exp_gnt) begin
        report_mismatch("lsu_gnt_o", 64'(lsu_gnt_o), 64'(exp_gnt));
      end

      if (ild_req_i) begin
        a = int'({ild_addr_i[11:3], 3'b000});
        for (int b = 0; b < 8; b++) begin
          ild_exp[8*b +: 8] = imem[a + b];
          if (ild_we_i && ild_be_i[b]) imem[a + b] = ild_wdata_i[8*b +: 8];
        end
        ild_chk = !ild_we_i;
      end
      if (dld_req_i) begin
        a = int'({dld_addr_i[11:3], 3'b000});
        for (int b = 0; b < 8; b++) begin
          dld_exp[8*b +: 8] = dmem[a + b];
          if (dld_we_i && dld_be_i[b]) dmem[a + b] = dld_wdata_i[8*b +: 8];
        end
        dld_chk = !dld_we_i;
      end

      if (instr_req_i && instr_gnt_o) begin
        a = int'({instr_addr_i[11:2], 2'b00});
        for (int b = 0; b < 4; b++) if_exp[8*b +: 8] = imem[a + b];
        if_pend = 1'b1;
      end
      if (lsu_req_i && lsu_gnt_o) begin
        lsu_pend     = 1'b1;
        lsu_pend_rd  = !lsu_we_i;
        lsu_pend_loc = !exp_ext;
        if (exp_ext) begin
          lsu_exp = lsu_addr_i ^ 32'h5a5a5a5a;
          if (ext_addr_o !== lsu_addr_i) begin
            report_mismatch("ext_addr_o", 64'(ext_addr_o), 64'(lsu_addr_i));
          end
          if (ext_we_o !== lsu_we_i) begin
            report_mismatch("ext_we_o", 64'(ext_we_o), 64'(lsu_we_i));
          end
          if (ext_be_o !== lsu_be_i) begin
            report_mismatch("ext_be_o", 64'(ext_be_o), 64'(lsu_be_i));
          end
          if (ext_wdata_o !== lsu_wdata_i) begin
            report_mismatch("ext_wdata_o", 64'(ext_wdata_o), 64'(lsu_wdata_i));
          end
        end else begin
          a = int'({lsu_addr_i[11:2], 2'b00});
          for (int b = 0; b < 4; b++) begin
            lsu_exp[8*b +: 8] = dmem[a + b];
            if (lsu_we_i && lsu_be_i[b]) dmem[a + b] = lsu_wdata_i[8*b +: 8];
          end
        end
      end

      if (test_done_i) begin
        $display("test %0d done, %0d errors", test_idx_i, test_err);
        test_err = 0;
      end
      if (run_done_i) begin
        $display("checks %0d, mismatches %0d, other failures %0d",
                 checks, err_count_o, tb_fail_i);
      end
    end
  end

endmodule

`default_nettype wire

// File: verif/core_mem_region_tb.sv
// ************************************************************
// testbench for the memory region, default RAM sizes of 4 KB
// a stimulus table is applied in a loop, one access per entry
// the ext bus always grants and answers after 1 to 3 cycles
// ************************************************************
`default_nettype none

module core_mem_region_tb;

  localparam int N_TESTS     = 20;
  localparam int CYCLE_LIMIT = N_TESTS * 8 + 20;
  localparam int PORT_ILD    = 0;
  localparam int PORT_DLD    = 1;
  localparam int PORT_IF     = 2;
  localparam int PORT_LSU    = 3;

  typedef struct {
    int          port;
    logic        we;
    logic [31:0] addr;
    logic [7:0]  be;
    logic [63:0] wdata;
    logic [31:0] irq;
    logic        collide;
  } test_t;

  logic        clk;
  logic        rst_n;
  logic [31:0] irq_i;
  logic        irq_pending_o;
  logic [4:0]  irq_id_o;
  logic        instr_req_i;
  logic [31:0] instr_addr_i;
  logic        instr_gnt_o;
  logic        instr_rvalid_o;
  logic [31:0] instr_rdata_o;
  logic        lsu_req_i;
  logic        lsu_we_i;
  logic [31:0] lsu_addr_i;
  logic [3:0]  lsu_be_i;
  logic [31:0] lsu_wdata_i;
  logic        lsu_gnt_o;
  logic        lsu_rvalid_o;
  logic [31:0] lsu_rdata_o;
  logic        ext_req_o;
  logic        ext_we_o;
  logic [31:0] ext_addr_o;
  logic [3:0]  ext_be_o;
  logic [31:0] ext_wdata_o;
  logic        ext_gnt_i;
  logic        ext_rvalid_i;
  logic [31:0] ext_rdata_i;
  logic        ild_req_i;
  logic        ild_we_i;
  logic [31:0] ild_addr_i;
  logic [7:0]  ild_be_i;
  logic [63:0] ild_wdata_i;
  logic [63:0] ild_rdata_o;
  logic        dld_req_i;
  logic        dld_we_i;
  logic [31:0] dld_addr_i;
  logic [7:0]  dld_be_i;
  logic [63:0] dld_wdata_i;
  logic [63:0] dld_rdata_o;

  test_t       tests [N_TESTS];
  int          cycles;
  logic [31:0] tb_fail;
  logic [31:0] chk_err;
  logic        test_done;
  logic [31:0] test_idx;
  logic        run_done;

  core_mem_region dut (.*);

  core_mem_region_checker chk (
    .clk            (clk),
    .rst_n          (rst_n),
    .irq_i          (irq_i),
    .irq_pending_o  (irq_pending_o),
    .irq_id_o       (irq_id_o),
    .instr_req_i    (instr_req_i),
    .instr_addr_i   (instr_addr_i),
    .instr_gnt_o    (instr_gnt_o),
    .instr_rvalid_o (instr_rvalid_o),
    .instr_rdata_o  (instr_rdata_o),
    .lsu_req_i      (lsu_req_i),
    .lsu_we_i       (lsu_we_i),
    .lsu_addr_i     (lsu_addr_i),
    .lsu_be_i       (lsu_be_i),
    .lsu_wdata_i    (lsu_wdata_i),
    .lsu_gnt_o      (lsu_gnt_o),
    .lsu_rvalid_o   (lsu_rvalid_o),
    .lsu_rdata_o    (lsu_rdata_o),
    .ext_req_o      (ext_req_o),
    .ext_we_o       (ext_we_o),
    .ext_addr_o     (ext_addr_o),
    .ext_be_o       (ext_be_o),
    .ext_wdata_o    (ext_wdata_o),
    .ext_gnt_i      (ext_gnt_i),
    .ild_req_i      (ild_req_i),
    .ild_we_i       (ild_we_i),
    .ild_addr_i     (ild_addr_i),
    .ild_be_i       (ild_be_i),
    .ild_wdata_i    (ild_wdata_i),
    .ild_rdata_o    (ild_rdata_o),
    .dld_req_i      (dld_req_i),
    .dld_we_i       (dld_we_i),
    .dld_addr_i     (dld_addr_i),
    .dld_be_i       (dld_be_i),
    .dld_wdata_i    (dld_wdata_i),
    .dld_rdata_o    (dld_rdata_o),
    .test_done_i    (test_done),
    .test_idx_i     (test_idx),
    .run_done_i     (run_done),
    .tb_fail_i      (tb_fail),
    .err_count_o    (chk_err)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TEST FAILED");
      $finish;
    end
  end

  // external bus slave, answers with address xor 5a5a5a5a
  initial begin : ext_responder
    int          delay;
    logic [31:0] addr;
    ext_gnt_i    = 1'b1;
    ext_rvalid_i = 1'b0;
    ext_rdata_i  = '0;
    forever begin
      @(negedge clk);
      if (ext_req_o && ext_gnt_i) begin
        delay = int'($urandom % 3) + 1;
        addr  = ext_addr_o;
        @(posedge clk);
        repeat (delay - 1) @(posedge clk);
        #1;
        ext_rvalid_i = 1'b1;
        ext_rdata_i  = addr ^ 32'h5a5a5a5a;
        @(posedge clk);
        #1;
        ext_rvalid_i = 1'b0;
      end
    end
  end

  task automatic core_access(input int i);
    logic got;
    int   n;
    got = 1'b0;
    n   = 0;
    if (tests[i].port == PORT_IF) begin
      instr_req_i  = 1'b1;
      instr_addr_i = tests[i].addr;
    end else begin
      lsu_req_i   = 1'b1;
      lsu_we_i    = tests[i].we;
      lsu_addr_i  = tests[i].addr;
      lsu_be_i    = tests[i].be[3:0];
      lsu_wdata_i = tests[i].wdata[31:0];
    end
    // loader strobe into the same RAM in the same cycle
    if (tests[i].collide) begin
      if (tests[i].port == PORT_IF) begin
        ild_req_i   = 1'b1;
        ild_we_i    = 1'b1;
        ild_addr_i  = tests[i].addr;
        ild_be_i    = 8'hff;
        ild_wdata_i = tests[i].wdata;
      end else begin
        dld_req_i   = 1'b1;
        dld_we_i    = 1'b1;
        dld_addr_i  = tests[i].addr;
        dld_be_i    = 8'hff;
        dld_wdata_i = tests[i].wdata;
      end
    end
    while (!got && n < 8) begin
      @(negedge clk);
      got = (tests[i].port == PORT_IF) ? instr_gnt_o : lsu_gnt_o;
      @(posedge clk);
      #1;
      ild_req_i = 1'b0;
      dld_req_i = 1'b0;
      n++;
    end
    instr_req_i = 1'b0;
    lsu_req_i   = 1'b0;
    if (!got) begin
      $display("test %0d: request was never granted", i);
      tb_fail = tb_fail + 1;
    end else begin
      got = 1'b0;
      n   = 0;
      while (!got && n < 8) begin
        @(negedge clk);
        got = (tests[i].port == PORT_IF) ? instr_rvalid_o : lsu_rvalid_o;
        n++;
      end
      if (!got) begin
        $display("test %0d: no rvalid arrived after the grant", i);
        tb_fail = tb_fail + 1;
      end
      @(posedge clk);
      #1;
    end
  endtask

  task automatic apply_test(input int i);
    irq_i = tests[i].irq;
    if (tests[i].port == PORT_ILD) begin
      ild_req_i   = 1'b1;
      ild_we_i    = tests[i].we;
      ild_addr_i  = tests[i].addr;
      ild_be_i    = tests[i].be;
      ild_wdata_i = tests[i].wdata;
    end else if (tests[i].port == PORT_DLD) begin
      dld_req_i   = 1'b1;
      dld_we_i    = tests[i].we;
      dld_addr_i  = tests[i].addr;
      dld_be_i    = tests[i].be;
      dld_wdata_i = tests[i].wdata;
    end else begin
      core_access(i);
    end
    if (tests[i].port == PORT_ILD || tests[i].port == PORT_DLD) begin
      @(posedge clk);
      #1;
      ild_req_i = 1'b0;
      dld_req_i = 1'b0;
      // loader read data shows up one cycle after the strobe
      @(posedge clk);
      #1;
    end
    test_idx  = i;
    test_done = 1'b1;
    @(posedge clk);
    #1;
    test_done = 1'b0;
  endtask

  initial begin
    void'($urandom(32'h9e8));
    cycles       = 0;
    tb_fail      = '0;
    test_done    = 1'b0;
    test_idx     = '0;
    run_done     = 1'b0;
    rst_n        = 1'b0;
    irq_i        = '0;
    instr_req_i  = 1'b0;
    instr_addr_i = '0;
    lsu_req_i    = 1'b0;
    lsu_we_i     = 1'b0;
    lsu_addr_i   = '0;
    lsu_be_i     = '0;
    lsu_wdata_i  = '0;
    ild_req_i    = 1'b0;
    ild_we_i     = 1'b0;
    ild_addr_i   = '0;
    ild_be_i     = '0;
    ild_wdata_i  = '0;
    dld_req_i    = 1'b0;
    dld_we_i     = 1'b0;
    dld_addr_i   = '0;
    dld_be_i     = '0;
    dld_wdata_i  = '0;

    // port, we, addr, be, wdata, irq, collide
    tests[0]  = '{PORT_ILD, 1'b1, 32'h0000_0000, 8'hff, 64'h1122334455667788, 32'h0, 1'b0};
    tests[1]  = '{PORT_ILD, 1'b1, 32'h0000_0008, 8'hff, 64'hcafef00ddeadbeef, 32'h1, 1'b0};
    tests[2]  = '{PORT_ILD, 1'b1, 32'h0000_0010, 8'h0f, 64'h0000000076543210, 32'h0, 1'b0};
    tests[3]  = '{PORT_ILD, 1'b0, 32'h0000_0008, 8'h00, 64'h0, 32'h2, 1'b0};
    tests[4]  = '{PORT_IF,  1'b0, 32'h0000_0000, 8'h00, 64'h0, 32'h8000_0001, 1'b0};
    tests[5]  = '{PORT_IF,  1'b0, 32'h0000_0004, 8'h00, 64'h0, 32'h0, 1'b0};
    tests[6]  = '{PORT_IF,  1'b0, 32'h0000_000c, 8'h00, 64'h0, 32'h0001_0100, 1'b0};
    tests[7]  = '{PORT_IF,  1'b0, 32'h0000_0010, 8'h00, 64'h0, 32'h4000_0000, 1'b0};
    tests[8]  = '{PORT_DLD, 1'b1, 32'h0010_0020, 8'hff, 64'h0, 32'h8, 1'b0};
    tests[9]  = '{PORT_LSU, 1'b1, 32'h0010_0024, 8'h05, 64'haabbccdd, 32'h0, 1'b0};
    tests[10] = '{PORT_LSU, 1'b1, 32'h0010_0020, 8'h08, 64'h99000000, 32'h0, 1'b0};
    tests[11] = '{PORT_LSU, 1'b0, 32'h0010_0020, 8'h0f, 64'h0, 32'h0, 1'b0};
    tests[12] = '{PORT_LSU, 1'b0, 32'h0010_0024, 8'h0f, 64'h0, 32'h0, 1'b0};
    tests[13] = '{PORT_DLD, 1'b0, 32'h0010_0020, 8'h00, 64'h0, 32'hffff_ffff, 1'b0};
    tests[14] = '{PORT_LSU, 1'b1, 32'h2000_0020, 8'h0f, 64'h12345678, 32'h0, 1'b0};
    tests[15] = '{PORT_LSU, 1'b0, 32'h3000_0024, 8'h0f, 64'h0, 32'h10, 1'b0};
    tests[16] = '{PORT_DLD, 1'b0, 32'h0010_0020, 8'h00, 64'h0, 32'h0, 1'b0};
    tests[17] = '{PORT_IF,  1'b0, 32'h0000_0008, 8'h00, 64'h0badc0de00c0ffee, 32'h0, 1'b1};
    tests[18] = '{PORT_LSU, 1'b0, 32'h0010_0024, 8'h0f, 64'h0102030405060708, 32'h0, 1'b1};
    tests[19] = '{PORT_DLD, 1'b0, 32'h0010_0020, 8'h00, 64'h0, 32'h0, 1'b0};

    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    for (int i = 0; i < N_TESTS; i++) begin
      apply_test(i);
    end

    run_done = 1'b1;
    @(posedge clk);
    #1;
    if (chk_err == 0 && tb_fail == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: core_mem_region.f
source/core_region_pkg.sv
source/irq_id_encoder.sv
source/lsu_demux.sv
source/ram_arbiter.sv
source/sp_ram.sv
source/core_mem_region.sv
verif/core_mem_region_checker.sv
verif/core_mem_region_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the memory region testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing \
  --top-module core_mem_region_tb \
  -f core_mem_region.f \
  -o core_mem_region_sim

./obj_dir/core_mem_region_sim | tee sim.log

if grep -q "TEST PASSED" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
